//--- files.f
source/pipe_pkg.sv
source/isa_pkg.sv
source/inst_decoder.sv
source/operand_forward.sv
source/branch_resolve.sv
source/id_ex_reg.sv
source/decode_stage.sv
tb/decode_stage_assert.sv
tb/tb_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the decode stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_decode_stage -f files.f --Mdir "$build_dir" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

"./$build_dir/sim_tb" | tee "$log"
status=${PIPESTATUS[0]}
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All tests passed" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1

//--- source/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve import pipe_pkg::*; (
	input  br_cond_e          br_cond_i,
	input  logic [data_w-1:0] op1_i,
	input  logic [data_w-1:0] op2_i,
	input  logic [data_w-1:0] imm_i,
	input  logic [data_w-1:0] jump_target_i,
	output logic              branch_flag_o,
	output logic [data_w-1:0] target_addr_o
);

	logic [data_w:0] diff;
	logic            borrow;
	logic            zero;

	// single unsigned subtract, borrow means op1 < op2
	assign diff   = {1'b0, op1_i} - {1'b0, op2_i};
	assign borrow = diff[data_w];
	assign zero   = (diff[data_w-1:0] == '0);

	always_comb begin
		case (br_cond_i)
			br_always: branch_flag_o = 1'b1;
			br_eq:     branch_flag_o = zero;
			br_ne:     branch_flag_o = !zero;
			br_gt:     branch_flag_o = !borrow && !zero;
			br_lt:     branch_flag_o = borrow;
			br_le:     branch_flag_o = borrow || zero;
			br_ge:     branch_flag_o = !borrow;
			default:   branch_flag_o = 1'b0;
		endcase
	end

	always_comb begin
		if (!branch_flag_o)
			target_addr_o = '0;
		else if (br_cond_i == br_always)
			target_addr_o = jump_target_i;
		else
			target_addr_o = imm_i;
	end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [inst_w-1:0]     inst_i,
	output logic                  reg1_read_o,
	output logic [reg_addr_w-1:0] reg1_addr_o,
	output logic                  reg2_read_o,
	output logic [reg_addr_w-1:0] reg2_addr_o,
	input  logic [data_w-1:0]     reg1_data_i,
	input  logic [data_w-1:0]     reg2_data_i,
	input  logic                  ex_wreg_i,
	input  logic [reg_addr_w-1:0] ex_wd_i,
	input  logic [data_w-1:0]     ex_wdata_i,
	input  logic                  mem_wreg_i,
	input  logic [reg_addr_w-1:0] mem_wd_i,
	input  logic [data_w-1:0]     mem_wdata_i,
	output logic                  branch_flag_o,
	output logic [data_w-1:0]     target_addr_o,
	output logic                  stall_o,
	output alu_op_e               ex_aluop_o,
	output alu_sel_e              ex_alusel_o,
	output logic [data_w-1:0]     ex_op1_o,
	output logic [data_w-1:0]     ex_op2_o,
	output logic [reg_addr_w-1:0] ex_wd_o,
	output logic                  ex_wreg_o
);

	alu_op_e               aluop;
	alu_sel_e              alusel;
	br_cond_e              br_cond;
	logic [data_w-1:0]     imm;
	logic [data_w-1:0]     jump_target;
	logic [data_w-1:0]     op1;
	logic [data_w-1:0]     op2;
	logic [reg_addr_w-1:0] wd;
	logic                  wreg;
	logic                  ex_load;

	// stall compares against the destination held in id/ex
	inst_decoder u_decoder (
		.inst_i        (inst_i),
		.ex_load_i     (ex_load),
		.ex_wd_i       (ex_wd_o),
		.aluop_o       (aluop),
		.alusel_o      (alusel),
		.br_cond_o     (br_cond),
		.imm_o         (imm),
		.jump_target_o (jump_target),
		.reg1_read_o   (reg1_read_o),
		.reg2_read_o   (reg2_read_o),
		.reg1_addr_o   (reg1_addr_o),
		.reg2_addr_o   (reg2_addr_o),
		.wd_o          (wd),
		.wreg_o        (wreg),
		.stall_o       (stall_o)
	);

	operand_forward u_fwd1 (
		.read_i      (reg1_read_o),
		.addr_i      (reg1_addr_o),
		.reg_data_i  (reg1_data_i),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (op1)
	);

	operand_forward u_fwd2 (
		.read_i      (reg2_read_o),
		.addr_i      (reg2_addr_o),
		.reg_data_i  (reg2_data_i),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (op2)
	);

	branch_resolve u_branch (
		.br_cond_i     (br_cond),
		.op1_i         (op1),
		.op2_i         (op2),
		.imm_i         (imm),
		.jump_target_i (jump_target),
		.branch_flag_o (branch_flag_o),
		.target_addr_o (target_addr_o)
	);

	id_ex_reg u_id_ex (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.stall_i     (stall_o),
		.aluop_i     (aluop),
		.alusel_i    (alusel),
		.op1_i       (op1),
		.op2_i       (op2),
		.wd_i        (wd),
		.wreg_i      (wreg),
		.ex_aluop_o  (ex_aluop_o),
		.ex_alusel_o (ex_alusel_o),
		.ex_op1_o    (ex_op1_o),
		.ex_op2_o    (ex_op2_o),
		.ex_wd_o     (ex_wd_o),
		.ex_wreg_o   (ex_wreg_o),
		.ex_load_o   (ex_load)
	);

endmodule

//--- source/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg import pipe_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  stall_i,
	input  alu_op_e               aluop_i,
	input  alu_sel_e              alusel_i,
	input  logic [data_w-1:0]     op1_i,
	input  logic [data_w-1:0]     op2_i,
	input  logic [reg_addr_w-1:0] wd_i,
	input  logic                  wreg_i,
	output alu_op_e               ex_aluop_o,
	output alu_sel_e              ex_alusel_o,
	output logic [data_w-1:0]     ex_op1_o,
	output logic [data_w-1:0]     ex_op2_o,
	output logic [reg_addr_w-1:0] ex_wd_o,
	output logic                  ex_wreg_o,
	output logic                  ex_load_o
);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_aluop_o  <= alu_nop;
			ex_alusel_o <= sel_nop;
			ex_wreg_o   <= 1'b0;
		end else if (stall_i) begin
			// bubble while decode repeats the instruction
			ex_aluop_o  <= alu_nop;
			ex_alusel_o <= sel_nop;
			ex_wreg_o   <= 1'b0;
		end else begin
			ex_aluop_o  <= aluop_i;
			ex_alusel_o <= alusel_i;
			ex_wreg_o   <= wreg_i;
		end
	end

	always_ff @(posedge clk_i) begin
		ex_op1_o <= op1_i;
		ex_op2_o <= op2_i;
		ex_wd_o  <= wd_i;
	end

	assign ex_load_o = (ex_aluop_o == alu_loadw);

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
	input  logic [inst_w-1:0]     inst_i,
	input  logic                  ex_load_i,
	input  logic [reg_addr_w-1:0] ex_wd_i,
	output alu_op_e               aluop_o,
	output alu_sel_e              alusel_o,
	output br_cond_e              br_cond_o,
	output logic [data_w-1:0]     imm_o,
	output logic [data_w-1:0]     jump_target_o,
	output logic                  reg1_read_o,
	output logic                  reg2_read_o,
	output logic [reg_addr_w-1:0] reg1_addr_o,
	output logic [reg_addr_w-1:0] reg2_addr_o,
	output logic [reg_addr_w-1:0] wd_o,
	output logic                  wreg_o,
	output logic                  stall_o
);

	fmt_e                  fmt;
	op_e                   op;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] ra;
	logic [reg_addr_w-1:0] rb;
	logic [data_w-1:0]     imm_field;
	logic [data_w-1:0]     mov_imm;
	logic [data_w-1:0]     jmp_field;

	function automatic alu_op_e to_aluop(input op_e code);
		case (code)
			op_or:    return alu_or;
			op_and:   return alu_and;
			op_xor:   return alu_xor;
			op_not:   return alu_not;
			op_shl:   return alu_shl;
			op_shr:   return alu_shr;
			op_sar:   return alu_sar;
			op_mov:   return alu_mov;
			op_add:   return alu_add;
			op_sub:   return alu_sub;
			op_loadw: return alu_loadw;
			op_jmp:   return alu_jmp;
			op_je:    return alu_je;
			op_jne:   return alu_jne;
			op_jg:    return alu_jg;
			op_jl:    return alu_jl;
			op_jng:   return alu_jng;
			op_jnl:   return alu_jnl;
			default:  return alu_nop;
		endcase
	endfunction

	function automatic alu_sel_e to_alusel(input op_e code);
		case (code)
			op_or, op_and, op_xor, op_not: return sel_logic;
			op_shl, op_shr, op_sar:        return sel_shift;
			op_mov:                        return sel_mov;
			op_add, op_sub:                return sel_arith;
			op_loadw:                      return sel_load;
			default:                       return sel_jump;
		endcase
	endfunction

	assign fmt       = fmt_e'(inst_i[fmt_msb:fmt_lsb]);
	assign op        = op_e'(inst_i[op_msb:op_lsb]);
	assign rd        = inst_i[rd_msb:rd_lsb];
	assign ra        = inst_i[ra_msb:ra_lsb];
	assign rb        = inst_i[rb_msb:rb_lsb];
	assign imm_field = inst_i[imm_msb:imm_lsb];
	assign mov_imm   = inst_i[mov_imm_msb:mov_imm_lsb];
	assign jmp_field = inst_i[jmp_msb:jmp_lsb];

	always_comb begin
		// invalid encodings fall through as nop
		aluop_o       = alu_nop;
		alusel_o      = sel_nop;
		br_cond_o     = br_none;
		imm_o         = '0;
		jump_target_o = '0;
		reg1_read_o   = 1'b0;
		reg2_read_o   = 1'b0;
		reg1_addr_o   = '0;
		reg2_addr_o   = '0;
		wd_o          = '0;
		wreg_o        = 1'b0;
		case (fmt)
			fmt_sreg: begin
				case (op)
					op_or, op_and, op_xor, op_shl, op_shr, op_sar,
					op_add, op_sub, op_loadw: begin
						aluop_o     = to_aluop(op);
						alusel_o    = to_alusel(op);
						reg1_read_o = 1'b1;
						reg1_addr_o = ra;
						imm_o       = imm_field;
						wd_o        = rd;
						wreg_o      = 1'b1;
					end
					op_mov: begin
						aluop_o  = alu_mov;
						alusel_o = sel_mov;
						imm_o    = mov_imm;
						wd_o     = rd;
						wreg_o   = 1'b1;
					end
					op_je, op_jne, op_jg, op_jl, op_jng, op_jnl: begin
						aluop_o     = to_aluop(op);
						alusel_o    = sel_jump;
						reg1_read_o = 1'b1;
						reg2_read_o = 1'b1;
						reg1_addr_o = rd;
						reg2_addr_o = ra;
						imm_o       = imm_field;
						case (op)
							op_je:   br_cond_o = br_eq;
							op_jne:  br_cond_o = br_ne;
							op_jg:   br_cond_o = br_gt;
							op_jl:   br_cond_o = br_lt;
							op_jng:  br_cond_o = br_le;
							default: br_cond_o = br_ge;
						endcase
					end
					op_jmp: begin
						aluop_o       = alu_jmp;
						alusel_o      = sel_jump;
						jump_target_o = jmp_field;
						br_cond_o     = br_always;
					end
					default: ;
				endcase
			end
			fmt_dreg: begin
				case (op)
					op_or, op_and, op_xor, op_shl, op_shr, op_sar, op_add, op_sub: begin
						aluop_o     = to_aluop(op);
						alusel_o    = to_alusel(op);
						reg1_read_o = 1'b1;
						reg2_read_o = 1'b1;
						reg1_addr_o = ra;
						reg2_addr_o = rb;
						wd_o        = rd;
						wreg_o      = 1'b1;
					end
					// unary, only register a
					op_not, op_mov: begin
						aluop_o     = to_aluop(op);
						alusel_o    = to_alusel(op);
						reg1_read_o = 1'b1;
						reg1_addr_o = ra;
						wd_o        = rd;
						wreg_o      = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// load in id/ex whose result is needed now
	assign stall_o = ex_load_i &&
		((reg1_read_o && (reg1_addr_o == ex_wd_i)) ||
		 (reg2_read_o && (reg2_addr_o == ex_wd_i)));

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

	localparam int inst_w = 64;

	// instruction word layout
	localparam int fmt_msb     = 63;
	localparam int fmt_lsb     = 60;
	localparam int op_msb      = 59;
	localparam int op_lsb      = 52;
	localparam int rd_msb      = 51;
	localparam int rd_lsb      = 47;
	localparam int ra_msb      = 46;
	localparam int ra_lsb      = 42;
	localparam int rb_msb      = 41;
	localparam int rb_lsb      = 37;
	localparam int imm_msb     = 41;
	localparam int imm_lsb     = 10;
	localparam int mov_imm_msb = 46;
	localparam int mov_imm_lsb = 15;
	localparam int jmp_msb     = 51;
	localparam int jmp_lsb     = 20;

	// other format codes are invalid
	typedef enum logic [3:0] {
		fmt_sreg = 4'h1,
		fmt_dreg = 4'h2
	} fmt_e;

	typedef enum logic [7:0] {
		op_or    = 8'h01,
		op_and   = 8'h02,
		op_xor   = 8'h03,
		op_not   = 8'h04,
		op_shl   = 8'h08,
		op_shr   = 8'h09,
		op_sar   = 8'h0a,
		op_mov   = 8'h10,
		op_add   = 8'h18,
		op_sub   = 8'h19,
		op_loadw = 8'h20,
		op_jmp   = 8'h30,
		op_je    = 8'h31,
		op_jne   = 8'h32,
		op_jg    = 8'h33,
		op_jl    = 8'h34,
		op_jng   = 8'h35,
		op_jnl   = 8'h36
	} op_e;

endpackage

//--- source/operand_forward.sv
`timescale 1ns/1ns

module operand_forward import pipe_pkg::*; (
	input  logic                  read_i,
	input  logic [reg_addr_w-1:0] addr_i,
	input  logic [data_w-1:0]     reg_data_i,
	input  logic [data_w-1:0]     imm_i,
	input  logic                  ex_wreg_i,
	input  logic [reg_addr_w-1:0] ex_wd_i,
	input  logic [data_w-1:0]     ex_wdata_i,
	input  logic                  mem_wreg_i,
	input  logic [reg_addr_w-1:0] mem_wd_i,
	input  logic [data_w-1:0]     mem_wdata_i,
	output logic [data_w-1:0]     operand_o
);

	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		// youngest result wins
		else if (ex_wreg_i && (ex_wd_i == addr_i))
			operand_o = ex_wdata_i;
		else if (mem_wreg_i && (mem_wd_i == addr_i))
			operand_o = mem_wdata_i;
		else
			operand_o = reg_data_i;
	end

endmodule

//--- source/pipe_pkg.sv
package pipe_pkg;

	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;

	typedef enum logic [4:0] {
		alu_nop,
		alu_or,
		alu_and,
		alu_xor,
		alu_not,
		alu_shl,
		alu_shr,
		alu_sar,
		alu_mov,
		alu_add,
		alu_sub,
		alu_loadw,
		alu_jmp,
		alu_je,
		alu_jne,
		alu_jg,
		alu_jl,
		alu_jng,
		alu_jnl
	} alu_op_e;

	// result group seen by the execute stage
	typedef enum logic [2:0] {
		sel_nop,
		sel_logic,
		sel_shift,
		sel_mov,
		sel_arith,
		sel_load,
		sel_jump
	} alu_sel_e;

	// jump conditions, all compared unsigned
	typedef enum logic [2:0] {
		br_none,
		br_always,
		br_eq,
		br_ne,
		br_gt,
		br_lt,
		br_le,
		br_ge
	} br_cond_e;

endpackage

//--- tb/decode_stage_assert.sv
`timescale 1ns/1ns

module decode_stage_assert import pipe_pkg::*; (
	input logic    clk_i,
	input logic    rst_n_i,
	input logic    stall_i,
	input logic    branch_flag_i,
	input logic    ex_wreg_i,
	input alu_op_e ex_aluop_i
);

	// id/ex is empty on the edge after any reset sample
	a_reset_clears: assert property (@(posedge clk_i)
		!rst_n_i |=> !ex_wreg_i && ex_aluop_i == alu_nop)
		else $error("id/ex not cleared by reset");

	a_stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> !ex_wreg_i && ex_aluop_i == alu_nop)
		else $error("stall cycle not followed by a bubble");

	a_branch_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		branch_flag_i |=> !ex_wreg_i)
		else $error("taken branch loaded a register write into id/ex");

endmodule

bind decode_stage decode_stage_assert u_assert (
	.clk_i         (clk_i),
	.rst_n_i       (rst_n_i),
	.stall_i       (stall_o),
	.branch_flag_i (branch_flag_o),
	.ex_wreg_i     (ex_wreg_o),
	.ex_aluop_i    (ex_aluop_o)
);

//--- tb/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage import isa_pkg::*, pipe_pkg::*; ();

	localparam int half_period  = 20;
	localparam int reset_cycles = 8;
	// the tests need about 115 cycles
	localparam int timeout_cycles = 2000;
	localparam logic [inst_w-1:0] idle_inst = '0;

	logic                  clk_i;
	logic                  rst_n_i;
	logic [inst_w-1:0]     inst_i;
	logic                  reg1_read_o;
	logic [reg_addr_w-1:0] reg1_addr_o;
	logic                  reg2_read_o;
	logic [reg_addr_w-1:0] reg2_addr_o;
	logic [data_w-1:0]     reg1_data_i;
	logic [data_w-1:0]     reg2_data_i;
	logic                  ex_wreg_i;
	logic [reg_addr_w-1:0] ex_wd_i;
	logic [data_w-1:0]     ex_wdata_i;
	logic                  mem_wreg_i;
	logic [reg_addr_w-1:0] mem_wd_i;
	logic [data_w-1:0]     mem_wdata_i;
	logic                  branch_flag_o;
	logic [data_w-1:0]     target_addr_o;
	logic                  stall_o;
	alu_op_e               ex_aluop_o;
	alu_sel_e              ex_alusel_o;
	logic [data_w-1:0]     ex_op1_o;
	logic [data_w-1:0]     ex_op2_o;
	logic [reg_addr_w-1:0] ex_wd_o;
	logic                  ex_wreg_o;

	// register file model
	logic [data_w-1:0] regs [32];

	int    checks;
	int    errors;
	int    errors_at_start;
	int    cycle_count;
	string test_name;

	decode_stage i_dut (.*);

	assign reg1_data_i = regs[reg1_addr_o];
	assign reg2_data_i = regs[reg2_addr_o];

	initial begin
		clk_i = 1'b0;
		forever #half_period clk_i = ~clk_i;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", timeout_cycles);
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [inst_w-1:0] imm_word(input logic [3:0] fmt, input logic [7:0] op,
		input logic [4:0] rd, input logic [4:0] ra, input logic [31:0] imm);
		return {fmt, op, rd, ra, imm, 10'b0};
	endfunction

	function automatic logic [inst_w-1:0] dreg_word(input logic [7:0] op, input logic [4:0] rd,
		input logic [4:0] ra, input logic [4:0] rb);
		return {4'(fmt_dreg), op, rd, ra, rb, 37'b0};
	endfunction

	function automatic logic [data_w-1:0] forwarded(input logic [4:0] addr,
		input logic ex_en, input logic [4:0] ex_wd, input logic [data_w-1:0] ex_data,
		input logic mem_en, input logic [4:0] mem_wd, input logic [data_w-1:0] mem_data);
		if (ex_en && ex_wd == addr)
			return ex_data;
		if (mem_en && mem_wd == addr)
			return mem_data;
		return regs[addr];
	endfunction

	// unsigned compare, operand 1 against operand 2
	function automatic logic branch_taken(input op_e op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			op_je:   return a == b;
			op_jne:  return a != b;
			op_jg:   return a > b;
			op_jl:   return a < b;
			op_jng:  return a <= b;
			op_jnl:  return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			$display("%s: passed", test_name);
		end else begin
			$display("%s: failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic apply(input logic [inst_w-1:0] inst);
		@(posedge clk_i);
		inst_i <= inst;
		@(negedge clk_i);
	endtask

	// invalid word in decode, no forwarding
	task automatic idle_cycle();
		@(posedge clk_i);
		inst_i     <= idle_inst;
		ex_wreg_i  <= 1'b0;
		mem_wreg_i <= 1'b0;
		@(negedge clk_i);
	endtask

	task automatic reset_test();
		start_test("reset");
		repeat (reset_cycles / 2) @(posedge clk_i);
		@(negedge clk_i);
		check("ex_wreg during reset", 32'd0, 32'(ex_wreg_o));
		check("ex_aluop during reset", 32'(alu_nop), 32'(ex_aluop_o));
		check("stall during reset", 32'd0, 32'(stall_o));
		repeat (reset_cycles / 2) @(posedge clk_i);
		rst_n_i <= 1'b1;
		idle_cycle();
		check("ex_wreg after reset", 32'd0, 32'(ex_wreg_o));
		check("ex_aluop after reset", 32'(alu_nop), 32'(ex_aluop_o));
		check("stall after reset", 32'd0, 32'(stall_o));
		finish_test();
	endtask

	task automatic alu_case(input logic [3:0] fmt, input op_e op, input alu_op_e exp_op,
		input alu_sel_e exp_sel);
		logic [4:0]        rd;
		logic [4:0]        ra;
		logic [4:0]        rb;
		logic [31:0]       imm;
		logic [inst_w-1:0] inst;
		logic              read1;
		logic              read2;
		logic [31:0]       exp_op1;
		logic [31:0]       exp_op2;
		rd  = 5'($urandom());
		ra  = 5'($urandom());
		rb  = 5'($urandom());
		imm = $urandom();
		read1   = 1'b1;
		read2   = 1'b0;
		exp_op1 = regs[ra];
		exp_op2 = imm;
		if (fmt == fmt_sreg && op == op_mov) begin
			inst    = {4'(fmt_sreg), 8'(op_mov), rd, imm, 15'b0};
			read1   = 1'b0;
			exp_op1 = imm;
		end else if (fmt == fmt_sreg) begin
			inst = imm_word(fmt, op, rd, ra, imm);
		end else if (op == op_not || op == op_mov) begin
			inst    = dreg_word(op, rd, ra, rb);
			exp_op2 = 32'd0;
		end else begin
			inst    = dreg_word(op, rd, ra, rb);
			read2   = 1'b1;
			exp_op2 = regs[rb];
		end
		apply(inst);
		check("reg1_read", 32'(read1), 32'(reg1_read_o));
		check("reg2_read", 32'(read2), 32'(reg2_read_o));
		if (read1)
			check("reg1_addr", 32'(ra), 32'(reg1_addr_o));
		if (read2)
			check("reg2_addr", 32'(rb), 32'(reg2_addr_o));
		idle_cycle();
		check("ex_aluop", 32'(exp_op), 32'(ex_aluop_o));
		check("ex_alusel", 32'(exp_sel), 32'(ex_alusel_o));
		check("ex_op1", exp_op1, ex_op1_o);
		check("ex_op2", exp_op2, ex_op2_o);
		check("ex_wd", 32'(rd), 32'(ex_wd_o));
		check("ex_wreg", 32'd1, 32'(ex_wreg_o));
	endtask

	task automatic alu_test();
		start_test("alu_decode");
		alu_case(fmt_sreg, op_or, alu_or, sel_logic);
		alu_case(fmt_sreg, op_and, alu_and, sel_logic);
		alu_case(fmt_sreg, op_xor, alu_xor, sel_logic);
		alu_case(fmt_sreg, op_shl, alu_shl, sel_shift);
		alu_case(fmt_sreg, op_shr, alu_shr, sel_shift);
		alu_case(fmt_sreg, op_sar, alu_sar, sel_shift);
		alu_case(fmt_sreg, op_add, alu_add, sel_arith);
		alu_case(fmt_sreg, op_sub, alu_sub, sel_arith);
		alu_case(fmt_sreg, op_loadw, alu_loadw, sel_load);
		alu_case(fmt_sreg, op_mov, alu_mov, sel_mov);
		alu_case(fmt_dreg, op_or, alu_or, sel_logic);
		alu_case(fmt_dreg, op_and, alu_and, sel_logic);
		alu_case(fmt_dreg, op_xor, alu_xor, sel_logic);
		alu_case(fmt_dreg, op_not, alu_not, sel_logic);
		alu_case(fmt_dreg, op_shl, alu_shl, sel_shift);
		alu_case(fmt_dreg, op_shr, alu_shr, sel_shift);
		alu_case(fmt_dreg, op_sar, alu_sar, sel_shift);
		alu_case(fmt_dreg, op_add, alu_add, sel_arith);
		alu_case(fmt_dreg, op_sub, alu_sub, sel_arith);
		alu_case(fmt_dreg, op_mov, alu_mov, sel_mov);
		finish_test();
	endtask

	// pick 0 hits register a, 1 register b, 2 neither
	task automatic fwd_case(input logic [1:0] ex_pick, input logic ex_en,
		input logic [1:0] mem_pick, input logic mem_en);
		logic [4:0]  rd;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  ex_addr;
		logic [4:0]  mem_addr;
		logic [31:0] ex_data;
		logic [31:0] mem_data;
		rd       = 5'($urandom());
		ra       = 5'($urandom());
		rb       = ra + 5'd1;
		ex_addr  = ra + 5'(ex_pick);
		mem_addr = ra + 5'(mem_pick);
		ex_data  = $urandom();
		mem_data = $urandom();
		@(posedge clk_i);
		inst_i      <= dreg_word(op_add, rd, ra, rb);
		ex_wreg_i   <= ex_en;
		ex_wd_i     <= ex_addr;
		ex_wdata_i  <= ex_data;
		mem_wreg_i  <= mem_en;
		mem_wd_i    <= mem_addr;
		mem_wdata_i <= mem_data;
		idle_cycle();
		check("ex_op1", forwarded(ra, ex_en, ex_addr, ex_data, mem_en, mem_addr, mem_data),
			ex_op1_o);
		check("ex_op2", forwarded(rb, ex_en, ex_addr, ex_data, mem_en, mem_addr, mem_data),
			ex_op2_o);
	endtask

	task automatic forwarding_test();
		start_test("forwarding");
		fwd_case(2'd2, 1'b1, 2'd2, 1'b1);
		fwd_case(2'd0, 1'b1, 2'd2, 1'b1);
		fwd_case(2'd2, 1'b1, 2'd0, 1'b1);
		fwd_case(2'd0, 1'b1, 2'd0, 1'b1);
		fwd_case(2'd1, 1'b1, 2'd0, 1'b1);
		fwd_case(2'd0, 1'b0, 2'd0, 1'b1);
		fwd_case(2'd1, 1'b0, 2'd1, 1'b0);
		finish_test();
	endtask

	task automatic branch_case(input op_e op, input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  r1;
		logic [4:0]  r2;
		logic [31:0] target;
		logic        taken;
		r1     = 5'($urandom());
		r2     = r1 + 5'd1;
		target = $urandom();
		taken  = branch_taken(op, a, b);
		@(posedge clk_i);
		regs[r1] <= a;
		regs[r2] <= b;
		inst_i   <= imm_word(fmt_sreg, op, r1, r2, target);
		@(negedge clk_i);
		check("branch_flag", 32'(taken), 32'(branch_flag_o));
		check("target_addr", taken ? target : 32'd0, target_addr_o);
		check("stall", 32'd0, 32'(stall_o));
	endtask

	task automatic branch_test();
		op_e         conds [6];
		logic [31:0] value;
		logic [31:0] target;
		start_test("branches");
		conds = '{op_je, op_jne, op_jg, op_jl, op_jng, op_jnl};
		foreach (conds[i]) begin
			value = $urandom();
			branch_case(conds[i], $urandom(), $urandom());
			branch_case(conds[i], value, value);
			branch_case(conds[i], 32'h0000_0005, 32'hf000_0000);
			branch_case(conds[i], 32'hf000_0000, 32'h0000_0005);
		end
		target = $urandom();
		apply({4'(fmt_sreg), 8'(op_jmp), target, 20'b0});
		check("jmp branch_flag", 32'd1, 32'(branch_flag_o));
		check("jmp target_addr", target, target_addr_o);
		check("jmp reg reads", 32'd0, 32'({reg1_read_o, reg2_read_o}));
		idle_cycle();
		check("jmp ex_aluop", 32'(alu_jmp), 32'(ex_aluop_o));
		check("jmp ex_wreg", 32'd0, 32'(ex_wreg_o));
		finish_test();
	endtask

	// load into r5, then an add reading ra and rb
	task automatic load_use_case(input logic [4:0] ra, input logic [4:0] rb,
		input logic exp_stall);
		apply(imm_word(fmt_sreg, op_loadw, 5'd5, 5'd1, 32'h0000_0040));
		check("stall on load", 32'd0, 32'(stall_o));
		apply(dreg_word(op_add, 5'd7, ra, rb));
		check("stall", 32'(exp_stall), 32'(stall_o));
		check("load in id/ex", 32'(alu_loadw), 32'(ex_aluop_o));
		if (exp_stall) begin
			// inst_i stays put for one more cycle
			@(negedge clk_i);
			check("bubble ex_aluop", 32'(alu_nop), 32'(ex_aluop_o));
			check("bubble ex_wreg", 32'd0, 32'(ex_wreg_o));
			check("stall after bubble", 32'd0, 32'(stall_o));
		end
		idle_cycle();
		check("issued ex_aluop", 32'(alu_add), 32'(ex_aluop_o));
		check("issued ex_wreg", 32'd1, 32'(ex_wreg_o));
		check("issued ex_wd", 32'd7, 32'(ex_wd_o));
		check("issued ex_op1", regs[ra], ex_op1_o);
		check("issued ex_op2", regs[rb], ex_op2_o);
	endtask

	task automatic load_use_test();
		start_test("load_use");
		load_use_case(5'd5, 5'd2, 1'b1);
		load_use_case(5'd2, 5'd5, 1'b1);
		load_use_case(5'd1, 5'd2, 1'b0);
		finish_test();
	endtask

	task automatic invalid_case(input logic [inst_w-1:0] inst);
		apply(inst);
		check("reg reads", 32'd0, 32'({reg1_read_o, reg2_read_o}));
		check("branch_flag", 32'd0, 32'(branch_flag_o));
		check("target_addr", 32'd0, target_addr_o);
		check("stall", 32'd0, 32'(stall_o));
		idle_cycle();
		check("ex_aluop", 32'(alu_nop), 32'(ex_aluop_o));
		check("ex_alusel", 32'(sel_nop), 32'(ex_alusel_o));
		check("ex_wreg", 32'd0, 32'(ex_wreg_o));
	endtask

	task automatic invalid_test();
		start_test("invalid");
		invalid_case(imm_word(4'h7, op_add, 5'd3, 5'd4, 32'h1234_5678));
		invalid_case(imm_word(4'hf, op_je, 5'd3, 5'd3, 32'h0000_0100));
		invalid_case(imm_word(fmt_sreg, op_not, 5'd3, 5'd4, 32'h0000_0001));
		invalid_case(imm_word(fmt_sreg, 8'hff, 5'd3, 5'd4, 32'h0000_0001));
		invalid_case(dreg_word(op_loadw, 5'd3, 5'd4, 5'd6));
		invalid_case(dreg_word(op_jmp, 5'd3, 5'd4, 5'd6));
		finish_test();
	endtask

	initial begin
		checks = 0;
		errors = 0;
		rst_n_i     <= 1'b0;
		inst_i      <= idle_inst;
		ex_wreg_i   <= 1'b0;
		ex_wd_i     <= '0;
		ex_wdata_i  <= '0;
		mem_wreg_i  <= 1'b0;
		mem_wd_i    <= '0;
		mem_wdata_i <= '0;
		void'($urandom(95));
		foreach (regs[i])
			regs[i] <= $urandom();
		reset_test();
		alu_test();
		forwarding_test();
		branch_test();
		load_use_test();
		invalid_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
